// File: hw/reel_pixel_pipe.sv
/* raster to sprite coordinate stage
   picks the reel under the beam and scrolls it by that reel's offset */
`timescale 1ns/1ps

module reel_pixel_pipe import reel_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  hcount_t hcount,
    input  vcount_t vcount,
    input  logic    active_video,
    input  offset_t reel1_offset,
    input  offset_t reel2_offset,
    input  offset_t reel3_offset,
    output sprite_t sprite_idx,
    output coord_t  x_in_sprite,
    output coord_t  y_in_sprite,
    output logic    in_reel,
    output logic    video_on
);

    offset_t    reel_offset [3];
    logic [2:0] in_win;
    logic [1:0] sel;
    sprite_t    seq_pos;
    sprite_t    sprite_d;
    coord_t     x_d;
    coord_t     y_d;

    assign reel_offset[0] = reel1_offset;
    assign reel_offset[1] = reel2_offset;
    assign reel_offset[2] = reel3_offset;

    ////////////////////
    // window test and scroll
    always_comb begin
        offset_t y_reel;
        sel = 2'd0;
        // windows never overlap so at most one bit is set
        for (int r = 0; r < 3; r++) begin
            in_win[r] = (hcount >= REEL_START_H[r]) &&
                        (hcount < REEL_START_H[r] + hcount_t'(SPRITE_SIZE)) &&
                        (vcount >= REELS_START_V) &&
                        (vcount < REELS_START_V + REEL_DISPLAY_HEIGHT);
            if (in_win[r]) begin
                sel = 2'(r);
            end
        end

        // row in window plus scroll, folded back into one revolution
        y_reel = offset_t'(vcount - REELS_START_V) + reel_offset[sel];
        if (y_reel >= TOTAL_HEIGHT) begin
            y_reel = y_reel - TOTAL_HEIGHT;
        end

        // upper bits pick the sequence slot, lower bits the row in it
        seq_pos  = y_reel[8:6];
        sprite_d = REEL_SEQUENCE[sel][seq_pos];
        x_d      = coord_t'(hcount - REEL_START_H[sel]);
        y_d      = y_reel[5:0];
    end

    ////////////////////
    // stage 1 registers
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            in_reel  <= 1'b0;
            video_on <= 1'b0;
        end else begin
            in_reel  <= |in_win;
            video_on <= active_video;
        end
    end

    // coordinates only matter while in_reel is set
    always_ff @(posedge clk) begin
        sprite_idx  <= sprite_d;
        x_in_sprite <= x_d;
        y_in_sprite <= y_d;
    end

endmodule

// File: hw/reel_pkg.sv
/* slot reel display shared definitions
   raster geometry, sprite sizes, colours and the per-reel sprite order */
package reel_pkg;

    ////////////////////
    // basic types
    typedef logic [2:0]  sprite_t;
    typedef logic [9:0]  offset_t;
    typedef logic [5:0]  coord_t;
    typedef logic [2:0]  rgb_t;
    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;

    ////////////////////
    // sprite and reel geometry
    localparam int NUM_SPRITES = 7;
    // square sprites, width equals height
    localparam int SPRITE_SIZE = 64;
    // one full revolution, seven sprites stacked
    localparam offset_t TOTAL_HEIGHT = 10'd448;
    // three sprites tall
    localparam vcount_t REEL_DISPLAY_HEIGHT = 10'd192;
    localparam vcount_t REELS_START_V = 10'd40;
    // one sprite above the centred one
    localparam offset_t CENTER_OFFSET = 10'd64;
    // left edges of reels 1..3
    localparam hcount_t [0:2] REEL_START_H = '{11'd160, 11'd288, 11'd416};

    // green fill around the reels
    localparam rgb_t COLOR_BACKGROUND = 3'b010;

    // sprite order, top to bottom, per reel
    localparam sprite_t [0:2][0:6] REEL_SEQUENCE = '{
        '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6},
        '{3'd2, 3'd5, 3'd0, 3'd6, 3'd3, 3'd1, 3'd4},
        '{3'd5, 3'd3, 3'd1, 3'd4, 3'd2, 3'd0, 3'd6}
    };

    // reverse lookup: where a given sprite sits in a reel's sequence
    function automatic sprite_t target_position(input logic [1:0] reel, input sprite_t sprite);
        sprite_t pos;
        pos = '0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            if (REEL_SEQUENCE[reel][i] == sprite) begin
                pos = sprite_t'(i);
            end
        end
        return pos;
    endfunction

endpackage

// File: hw/reel_spin_ctrl.sv
/* reel spin controller
   frame tick from vsync, spin FSM, reel offsets and the req/ack handshake */
`timescale 1ns/1ps

module reel_spin_ctrl import reel_pkg::*; #(
    parameter int PIXELS_PER_FRAME = 2,
    parameter int BASE_SPINS       = 5,
    parameter int EXTRA_SPINS      = 2
) (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    vsync,
    input  logic    spin_req,
    input  sprite_t final_sprite1,
    input  sprite_t final_sprite2,
    input  sprite_t final_sprite3,
    output logic    spin_ack,
    output offset_t reel1_offset,
    output offset_t reel2_offset,
    output offset_t reel3_offset
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SPIN,
        ST_REEL1_STOP,
        ST_REEL2_STOP,
        ST_REEL3_STOP,
        ST_ACK
    } state_e;

    state_e  state_q, state_d;
    logic    vsync_prev;
    logic    frame_tick;
    offset_t off_q [3];
    offset_t off_d [3];
    // remaining full revolutions per reel
    logic [7:0] cnt_q [3];
    logic [7:0] cnt_d [3];
    sprite_t sprite_q [3];
    offset_t end_off [3];
    // per-reel phase flags, bit 0 is reel 1
    logic [2:0] spinning;
    logic [2:0] stopping;
    logic [2:0] last_wrap;

    // full-speed advance, wrap is handled by the caller
    function automatic offset_t spin_sum(input offset_t off);
        return off + offset_t'(PIXELS_PER_FRAME);
    endfunction

    // creep one line per frame until the target offset is reached
    function automatic offset_t stop_step(input offset_t off, input offset_t target);
        offset_t nxt;
        nxt = off;
        if (off != target) begin
            nxt = off + 10'd1;
            if (nxt >= TOTAL_HEIGHT) begin
                nxt = '0;
            end
        end
        return nxt;
    endfunction

    // offset that puts sequence position pos in the middle of the window
    function automatic offset_t ending_offset(input sprite_t pos);
        offset_t raw;
        raw = offset_t'(pos) * offset_t'(SPRITE_SIZE) + TOTAL_HEIGHT - CENTER_OFFSET;
        if (raw >= TOTAL_HEIGHT) begin
            raw = raw - TOTAL_HEIGHT;
        end
        return raw;
    endfunction

    ////////////////////
    // frame tick
    // one clock pulse after vsync (active low) falls
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vsync_prev <= 1'b1;
            frame_tick <= 1'b0;
        end else begin
            vsync_prev <= vsync;
            frame_tick <= vsync_prev & ~vsync;
        end
    end

    // capture the requested sprites while waiting in idle
    // requester keeps them stable until ack so relatching is harmless
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && spin_req) begin
            sprite_q[0] <= final_sprite1;
            sprite_q[1] <= final_sprite2;
            sprite_q[2] <= final_sprite3;
        end
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            end_off[i] = ending_offset(target_position(2'(i), sprite_q[i]));
        end
    end

    ////////////////////
    // spin FSM next state
    always_comb begin
        offset_t sum;
        state_d   = state_q;
        off_d     = off_q;
        cnt_d     = cnt_q;
        spinning  = 3'b000;
        stopping  = 3'b000;
        last_wrap = 3'b000;
        sum       = '0;

        // reels stop in order 1, 2, 3
        case (state_q)
            ST_SPIN: spinning = 3'b111;
            ST_REEL1_STOP: begin
                spinning = 3'b110;
                stopping = 3'b001;
            end
            ST_REEL2_STOP: begin
                spinning = 3'b100;
                stopping = 3'b011;
            end
            ST_REEL3_STOP: stopping = 3'b111;
            default: ;
        endcase

        for (int i = 0; i < 3; i++) begin
            if (spinning[i]) begin
                sum = spin_sum(off_q[i]);
                if (sum >= TOTAL_HEIGHT) begin
                    off_d[i] = sum - TOTAL_HEIGHT;
                    // count down one revolution per wrap
                    if (cnt_q[i] != '0) begin
                        cnt_d[i] = cnt_q[i] - 8'd1;
                    end else begin
                        last_wrap[i] = 1'b1;
                    end
                end else begin
                    off_d[i] = sum;
                end
            end else if (stopping[i]) begin
                off_d[i] = stop_step(off_q[i], end_off[i]);
            end
        end

        case (state_q)
            ST_IDLE: begin
                // previous ending offsets stay as the new start
                if (spin_req) begin
                    state_d  = ST_SPIN;
                    cnt_d[0] = 8'(BASE_SPINS);
                    cnt_d[1] = 8'(EXTRA_SPINS);
                    cnt_d[2] = 8'(EXTRA_SPINS);
                end
            end
            ST_SPIN:       if (last_wrap[0]) state_d = ST_REEL1_STOP;
            ST_REEL1_STOP: if (last_wrap[1]) state_d = ST_REEL2_STOP;
            ST_REEL2_STOP: if (last_wrap[2]) state_d = ST_REEL3_STOP;
            ST_REEL3_STOP: begin
                // done once every reel sits on its target
                if (off_d[0] == end_off[0] && off_d[1] == end_off[1] &&
                    off_d[2] == end_off[2]) begin
                    state_d = ST_ACK;
                end
            end
            // hold ack until the requester lets go
            ST_ACK: if (!spin_req) state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    // spin phases move on frame ticks, the ack release on any clock
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= ST_IDLE;
            for (int i = 0; i < 3; i++) begin
                off_q[i] <= '0;
                cnt_q[i] <= '0;
            end
        end else begin
            if (frame_tick || state_q == ST_ACK) begin
                state_q <= state_d;
            end
            if (frame_tick) begin
                off_q <= off_d;
                cnt_q <= cnt_d;
            end
        end
    end

    assign spin_ack     = (state_q == ST_ACK);
    assign reel1_offset = off_q[0];
    assign reel2_offset = off_q[1];
    assign reel3_offset = off_q[2];

endmodule

// File: hw/slot_display.sv
/* three reel slot machine display top
   spin control, coordinate pipe and shader on a 640x480 raster */
`timescale 1ns/1ps

module slot_display import reel_pkg::*; #(
    parameter int PIXELS_PER_FRAME = 2,
    parameter int BASE_SPINS       = 5,
    parameter int EXTRA_SPINS      = 2
) (
    input  logic    clk,
    input  logic    reset_n,
    input  hcount_t hcount,
    input  vcount_t vcount,
    input  logic    active_video,
    input  logic    vsync,
    input  logic    spin_req,
    input  sprite_t final_sprite1,
    input  sprite_t final_sprite2,
    input  sprite_t final_sprite3,
    output logic    spin_ack,
    output rgb_t    pixel_rgb
);

    // reel scroll positions, change only at frame ticks
    offset_t reel1_offset;
    offset_t reel2_offset;
    offset_t reel3_offset;

    // pipe to shader
    sprite_t sprite_idx;
    coord_t  x_in_sprite;
    coord_t  y_in_sprite;
    logic    in_reel;
    logic    video_on;

    reel_spin_ctrl #(
        .PIXELS_PER_FRAME (PIXELS_PER_FRAME),
        .BASE_SPINS       (BASE_SPINS),
        .EXTRA_SPINS      (EXTRA_SPINS)
    ) reel_spin_ctrl_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .vsync         (vsync),
        .spin_req      (spin_req),
        .final_sprite1 (final_sprite1),
        .final_sprite2 (final_sprite2),
        .final_sprite3 (final_sprite3),
        .spin_ack      (spin_ack),
        .reel1_offset  (reel1_offset),
        .reel2_offset  (reel2_offset),
        .reel3_offset  (reel3_offset)
    );

    // raster to pixel_rgb is three clocks
    reel_pixel_pipe reel_pixel_pipe_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .hcount       (hcount),
        .vcount       (vcount),
        .active_video (active_video),
        .reel1_offset (reel1_offset),
        .reel2_offset (reel2_offset),
        .reel3_offset (reel3_offset),
        .sprite_idx   (sprite_idx),
        .x_in_sprite  (x_in_sprite),
        .y_in_sprite  (y_in_sprite),
        .in_reel      (in_reel),
        .video_on     (video_on)
    );

    sprite_shader sprite_shader_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .sprite_idx  (sprite_idx),
        .x_in_sprite (x_in_sprite),
        .y_in_sprite (y_in_sprite),
        .in_reel     (in_reel),
        .video_on    (video_on),
        .pixel_rgb   (pixel_rgb)
    );

endmodule

// File: hw/sprite_shader.sv
/* sprite shader, draws a bordered solid sprite and
   chooses between sprite, background and blanking colour */
`timescale 1ns/1ps

module sprite_shader import reel_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  sprite_t sprite_idx,
    input  coord_t  x_in_sprite,
    input  coord_t  y_in_sprite,
    input  logic    in_reel,
    input  logic    video_on,
    output rgb_t    pixel_rgb
);

    logic border;
    rgb_t draw_q;
    logic in_reel_q;
    logic video_on_q;

    // one pixel black frame around every sprite
    assign border = (x_in_sprite == '0) || (x_in_sprite == coord_t'(SPRITE_SIZE - 1)) ||
                    (y_in_sprite == '0) || (y_in_sprite == coord_t'(SPRITE_SIZE - 1));

    ////////////////////
    // stage 2, draw
    // interior colour is index + 1 so sprite 0 is not black
    always_ff @(posedge clk) begin
        draw_q <= border ? rgb_t'(0) : rgb_t'(sprite_idx + 3'd1);
    end

    // control bits travel next to the drawn pixel
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            in_reel_q  <= 1'b0;
            video_on_q <= 1'b0;
        end else begin
            in_reel_q  <= in_reel;
            video_on_q <= video_on;
        end
    end

    ////////////////////
    // stage 3, colour select
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pixel_rgb <= '0;
        end else if (video_on_q && in_reel_q) begin
            pixel_rgb <= draw_q;
        end else if (video_on_q) begin
            pixel_rgb <= COLOR_BACKGROUND;
        end else begin
            // blanking must be black
            pixel_rgb <= '0;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the slot display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f slot_display.f \
    --top-module slot_display_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
out=$(./obj_dir/Vslot_display_tb +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
echo "simulation did not pass"
exit 1

// File: slot_display.f
hw/reel_pkg.sv
hw/reel_spin_ctrl.sv
hw/reel_pixel_pipe.sv
hw/sprite_shader.sv
hw/slot_display.sv
verification/slot_display_chk.sv
verification/slot_display_mon.sv
verification/slot_display_tb.sv

// File: verification/slot_display_chk.sv
/* slot display assertions
   handshake release and blanking colour, bound into the top level */
`timescale 1ns/1ps

module slot_display_chk import reel_pkg::*; (
    input logic clk,
    input logic reset_n,
    input logic active_video,
    input logic spin_req,
    input logic spin_ack,
    input rgb_t pixel_rgb
);

    // failed assertions so far
    int fail_count = 0;

    // no ack straight out of reset
    ack_low_after_reset: assert property (@(posedge clk) !reset_n |=> !spin_ack)
        else begin
            $error("spin_ack high right after reset");
            fail_count++;
        end

    // a held request keeps ack up
    ack_held_by_req: assert property (@(posedge clk) disable iff (!reset_n)
        spin_ack && spin_req |=> spin_ack)
        else begin
            $error("spin_ack fell while spin_req was high");
            fail_count++;
        end

    // blanking shows up black after the 3 clock pipe
    blank_is_black: assert property (@(posedge clk) disable iff (!reset_n)
        !$past(active_video, 3) |-> pixel_rgb == 3'd0)
        else begin
            $error("pixel_rgb not black three clocks after blanking");
            fail_count++;
        end

endmodule

// File: verification/slot_display_mon.sv
/* slot display monitor
   lines expected pixels up with pixel_rgb, checks ack release, reports per test */
`timescale 1ns/1ps

module slot_display_mon import reel_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  hcount_t hcount,
    input  vcount_t vcount,
    input  logic    spin_req,
    input  logic    spin_ack,
    input  rgb_t    pixel_rgb,
    input  logic    exp_valid,
    input  rgb_t    exp_rgb,
    input  int      test_num,
    input  logic    test_end,
    input  logic    report_req,
    output int      error_count
);

    // expected values aged by the pixel latency
    logic    pend_valid [3];
    rgb_t    pend_rgb   [3];
    hcount_t pend_h     [3];
    vcount_t pend_v     [3];
    logic    ack_prev;
    logic    req_prev;
    int      test_errors;
    int      test_checks;
    int      tests_run;
    int      tests_failed;
    int      checks;

    initial begin
        for (int i = 0; i < 3; i++) begin
            pend_valid[i] = 1'b0;
            pend_rgb[i]   = '0;
            pend_h[i]     = '0;
            pend_v[i]     = '0;
        end
        ack_prev     = 1'b0;
        req_prev     = 1'b0;
        test_errors  = 0;
        test_checks  = 0;
        tests_run    = 0;
        tests_failed = 0;
        checks       = 0;
        error_count  = 0;
    end

    always @(posedge clk) begin
        // pixel for the raster point seen three clocks ago
        if (pend_valid[2]) begin
            test_checks++;
            checks++;
            if (pixel_rgb !== pend_rgb[2]) begin
                $display("[ERROR] test %0d pixel_rgb at h=%0d v=%0d: got 0x%h, expected 0x%h",
                         test_num, pend_h[2], pend_v[2], pixel_rgb, pend_rgb[2]);
                test_errors++;
                error_count++;
            end
        end
        // ack may only drop once the request is gone
        if (reset_n && ack_prev && !spin_ack && req_prev) begin
            $display("test %0d: spin_ack dropped while spin_req was still high", test_num);
            test_errors++;
            error_count++;
        end
        if (test_end) begin
            tests_run++;
            if (test_errors == 0) begin
                $display("test %0d: ok, %0d pixel checks", test_num, test_checks);
            end else begin
                tests_failed++;
                $display("test %0d: %0d errors in %0d pixel checks",
                         test_num, test_errors, test_checks);
            end
            test_errors = 0;
            test_checks = 0;
        end
        if (report_req) begin
            $display("tests %0d, failed %0d, pixel checks %0d, errors %0d",
                     tests_run, tests_failed, checks, error_count);
        end
        // age the expectations by one clock
        for (int i = 2; i > 0; i--) begin
            pend_valid[i] = pend_valid[i-1];
            pend_rgb[i]   = pend_rgb[i-1];
            pend_h[i]     = pend_h[i-1];
            pend_v[i]     = pend_v[i-1];
        end
        pend_valid[0] = exp_valid;
        pend_rgb[0]   = exp_rgb;
        pend_h[0]     = hcount;
        pend_v[0]     = vcount;
        ack_prev      = spin_ack;
        req_prev      = spin_req;
    end

endmodule

// File: verification/slot_display_tb.sv
/* slot display testbench
   raster probes, frame pulses and spin handshakes driven from a vector file */
`timescale 1ns/1ps

module slot_display_tb import reel_pkg::*; ();

    // frames allowed for one spin to settle
    localparam int FRAME_LIMIT    = 4000;
    // ack falls on the first clock that sees the request low
    localparam int ACK_DROP_LIMIT = 1;
    // top sprite of each reel at offset 0, plus one
    localparam rgb_t RESET_COLOUR [3] = '{3'd1, 3'd3, 3'd6};
    localparam rgb_t BG_COLOUR = 3'd2;

    logic    clk;
    logic    reset_n;
    hcount_t hcount;
    vcount_t vcount;
    logic    active_video;
    logic    vsync;
    logic    spin_req;
    sprite_t final_sprite1;
    sprite_t final_sprite2;
    sprite_t final_sprite3;
    logic    spin_ack;
    rgb_t    pixel_rgb;

    // expected values and test framing for the monitor
    logic    exp_valid;
    rgb_t    exp_rgb;
    int      test_num;
    logic    test_end;
    logic    report_req;
    int      error_count;
    // set when a wait runs out or the vectors are missing
    logic    aborted;

    // six fields per spin, sprites then colours
    int      vec_q [$];

    slot_display #(
        .PIXELS_PER_FRAME (2),
        .BASE_SPINS       (1),
        .EXTRA_SPINS      (1)
    ) slot_display_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .hcount        (hcount),
        .vcount        (vcount),
        .active_video  (active_video),
        .vsync         (vsync),
        .spin_req      (spin_req),
        .final_sprite1 (final_sprite1),
        .final_sprite2 (final_sprite2),
        .final_sprite3 (final_sprite3),
        .spin_ack      (spin_ack),
        .pixel_rgb     (pixel_rgb)
    );

    slot_display_mon mon_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .hcount      (hcount),
        .vcount      (vcount),
        .spin_req    (spin_req),
        .spin_ack    (spin_ack),
        .pixel_rgb   (pixel_rgb),
        .exp_valid   (exp_valid),
        .exp_rgb     (exp_rgb),
        .test_num    (test_num),
        .test_end    (test_end),
        .report_req  (report_req),
        .error_count (error_count)
    );

    bind slot_display slot_display_chk slot_display_chk_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .active_video (active_video),
        .spin_req     (spin_req),
        .spin_ack     (spin_ack),
        .pixel_rgb    (pixel_rgb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic load_vectors();
        int    fd;
        string line;
        int    s1;
        int    s2;
        int    s3;
        int    c1;
        int    c2;
        int    c3;
        fd = $fopen("verification/slot_display_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/slot_display_vectors.txt");
            aborted = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // comment lines start with a hash
                if (line.len() > 0 && line.getc(0) != 8'h23) begin
                    if ($sscanf(line, "%h %h %h %h %h %h", s1, s2, s3, c1, c2, c3) == 6) begin
                        vec_q.push_back(s1);
                        vec_q.push_back(s2);
                        vec_q.push_back(s3);
                        vec_q.push_back(c1);
                        vec_q.push_back(c2);
                        vec_q.push_back(c3);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one raster point, checked by the monitor three clocks later
    task automatic drive_probe(input hcount_t h, input vcount_t v, input logic av,
                               input rgb_t exp);
        @(posedge clk);
        hcount       <= h;
        vcount       <= v;
        active_video <= av;
        exp_valid    <= 1'b1;
        exp_rgb      <= exp;
    endtask

    // drain the pixel pipe, then mark the test as finished
    task automatic close_test();
        @(posedge clk);
        exp_valid    <= 1'b0;
        active_video <= 1'b0;
        repeat (4) @(posedge clk);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
        test_num <= test_num + 1;
    endtask

    // short frame, vsync low for two clocks
    task automatic pulse_frame();
        @(posedge clk);
        vsync <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        vsync <= 1'b1;
        @(posedge clk);
    endtask

    // full four-phase handshake for one spin, sets aborted on a timeout
    task automatic run_spin(input sprite_t s1, input sprite_t s2, input sprite_t s3);
        int frames;
        int cycles;
        frames = 0;
        cycles = 0;
        @(posedge clk);
        final_sprite1 <= s1;
        final_sprite2 <= s2;
        final_sprite3 <= s3;
        spin_req      <= 1'b1;
        @(negedge clk);
        // reels only move on frame ticks
        while (spin_ack !== 1'b1 && frames < FRAME_LIMIT) begin
            pulse_frame();
            @(negedge clk);
            frames++;
        end
        if (spin_ack !== 1'b1) begin
            $display("spin_ack did not rise within the frame limit");
            aborted = 1'b1;
        end else begin
            @(posedge clk);
            spin_req <= 1'b0;
            @(negedge clk);
            while (spin_ack !== 1'b0 && cycles < ACK_DROP_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (spin_ack !== 1'b0) begin
                $display("spin_ack stayed high after spin_req was released");
                aborted = 1'b1;
            end
        end
    endtask

    initial begin
        int   n_vec;
        rgb_t exp_c [3];
        reset_n       = 1'b0;
        hcount        = '0;
        vcount        = '0;
        active_video  = 1'b0;
        vsync         = 1'b1;
        spin_req      = 1'b0;
        final_sprite1 = '0;
        final_sprite2 = '0;
        final_sprite3 = '0;
        exp_valid     = 1'b0;
        exp_rgb       = '0;
        test_num      = 1;
        test_end      = 1'b0;
        report_req    = 1'b0;
        aborted       = 1'b0;

        load_vectors();
        n_vec = vec_q.size() / 6;
        if (n_vec == 0) begin
            $display("vector file holds no spin lines");
            aborted = 1'b1;
        end

        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(posedge clk);

        ////////////////////
        // blanking is black, background outside the reels
        drive_probe(11'd10, 10'd10, 1'b0, 3'd0);
        drive_probe(11'd200, 10'd100, 1'b0, 3'd0);
        drive_probe(11'd10, 10'd10, 1'b1, BG_COLOUR);
        drive_probe(11'd224, 10'd100, 1'b1, BG_COLOUR);
        drive_probe(11'd300, 10'd232, 1'b1, BG_COLOUR);
        drive_probe(11'd300, 10'd39, 1'b1, BG_COLOUR);
        close_test();

        // offsets at 0 show the first sprite of each sequence
        for (int r = 0; r < 3; r++) begin
            drive_probe(REEL_START_H[r] + 11'd1, REELS_START_V + 10'd1, 1'b1,
                        RESET_COLOUR[r]);
        end
        close_test();

        ////////////////////
        // back-to-back spins, each starting where the last one stopped
        for (int k = 0; k < n_vec; k++) begin
            run_spin(3'(vec_q[6*k]), 3'(vec_q[6*k+1]), 3'(vec_q[6*k+2]));
            if (aborted) begin
                break;
            end
            for (int r = 0; r < 3; r++) begin
                exp_c[r] = 3'(vec_q[6*k+3+r]);
            end
            for (int r = 0; r < 3; r++) begin
                // middle of the centred sprite
                drive_probe(REEL_START_H[r] + 11'd32, REELS_START_V + 10'd100, 1'b1,
                            exp_c[r]);
                // left border column of the same sprite
                drive_probe(REEL_START_H[r], REELS_START_V + 10'd100, 1'b1, 3'd0);
            end
            close_test();
        end

        @(posedge clk);
        report_req <= 1'b1;
        @(posedge clk);
        report_req <= 1'b0;
        @(negedge clk);
        if (!aborted && error_count == 0 &&
            slot_display_i.slot_display_chk_i.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verification/slot_display_vectors.txt
# one spin per line, hex fields
# final_sprite1 final_sprite2 final_sprite3 expected_rgb1 expected_rgb2 expected_rgb3
0 0 0 1 1 1
6 6 6 7 7 7
3 5 1 4 6 2
2 0 4 3 1 5
5 5 5 6 6 6
5 5 5 6 6 6
1 2 3 2 3 4
4 3 2 5 4 3
6 1 5 7 2 6
0 6 3 1 7 4
2 2 2 3 3 3
5 4 6 6 5 7
1 0 0 2 1 1
3 3 6 4 4 7
4 6 1 5 7 2
6 5 4 7 6 5
